/* common/ooo_pkg.sv */
/*
 * shared types and ALU opcodes for the out-of-order core
 * ALU ops only, sll uses b[4:0], slt is a signed compare giving 1 or 0
 */

package ooo_pkg;

	////////////////////////////////////////////////////////////
	// value widths
	////////////////////////////////////////////////////////////

	// one operand or result word
	typedef logic [31:0] data_t;

	// architectural register index, x0 hardwired to zero
	typedef logic [4:0] reg_idx_t;

	// ALU function select
	typedef logic [2:0] alu_op_t;

	////////////////////////////////////////////////////////////
	// ALU opcodes
	////////////////////////////////////////////////////////////

	// a + b
	localparam alu_op_t ALU_ADD = 3'd0;

	// a - b
	localparam alu_op_t ALU_SUB = 3'd1;

	// bitwise and
	localparam alu_op_t ALU_AND = 3'd2;

	// bitwise or
	localparam alu_op_t ALU_OR  = 3'd3;

	// bitwise xor
	localparam alu_op_t ALU_XOR = 3'd4;

	// a shifted left by b[4:0]
	localparam alu_op_t ALU_SLL = 3'd5;

	// signed a < b, result 1 or 0
	localparam alu_op_t ALU_SLT = 3'd6;

	// code 7 is unused, the ALU returns zero for it

endpackage

/* design/regfile.sv */
/*
 * 32 x 32 architectural registers, combinational reads, x0 reads zero
 * no write-to-read bypass, the map table still covers a committing register
 */

`timescale 1ns/1ps

module regfile
	import ooo_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  reg_idx_t rd_a_idx,
	input  reg_idx_t rd_b_idx,
	output data_t    rd_a_data,
	output data_t    rd_b_data,
	input  logic     wr_en,
	input  reg_idx_t wr_idx,
	input  data_t    wr_data
);

	// architectural state
	data_t regs [32];

	// read ports, x0 forced to zero
	assign rd_a_data = (rd_a_idx == '0) ? '0 : regs[rd_a_idx];
	assign rd_b_data = (rd_b_idx == '0) ? '0 : regs[rd_b_idx];

	// single write port from commit
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

/* design/map_table.sv */
/*
 * rename table, one busy bit and ROB tag per register, x0 never renamed
 * a dispatch to the register being cleared by commit takes priority
 */

`timescale 1ns/1ps

module map_table
	import ooo_pkg::*;
#(
	parameter  int ROB_DEPTH = 8,
	localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             dispatch,
	input  reg_idx_t         dispatch_rd,
	input  logic [TAG_W-1:0] alloc_tag,
	input  reg_idx_t         src_a_idx,
	input  reg_idx_t         src_b_idx,
	output logic             src_a_busy,
	output logic             src_b_busy,
	output logic [TAG_W-1:0] src_a_tag,
	output logic [TAG_W-1:0] src_b_tag,
	input  logic             commit,
	input  reg_idx_t         commit_rd,
	input  logic [TAG_W-1:0] commit_tag
);

	// busy means the value still lives in the ROB
	logic [31:0]      busy;
	logic [TAG_W-1:0] tags [32];

	// source lookups reflect state before this cycle's dispatch
	assign src_a_busy = busy[src_a_idx];
	assign src_b_busy = busy[src_b_idx];
	assign src_a_tag  = tags[src_a_idx];
	assign src_b_tag  = tags[src_b_idx];

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= '0;
		end else begin
			// clear only if no younger writer renamed the register since
			if (commit && busy[commit_rd] && tags[commit_rd] == commit_tag) begin
				busy[commit_rd] <= 1'b0;
			end
			// later assignment wins, keeps WAW order when both hit one register
			if (dispatch && dispatch_rd != '0) begin
				busy[dispatch_rd] <= 1'b1;
			end
		end
	end

	// tag payload
	always_ff @(posedge clock) begin
		if (dispatch && dispatch_rd != '0) begin
			tags[dispatch_rd] <= alloc_tag;
		end
	end

endmodule

/* design/rs/reservation_station.sv */
/*
 * RS_DEPTH entries (at least 2), lowest free entry on dispatch, oldest-index ready issue
 * an entry issuing this cycle still counts toward full
 */

`timescale 1ns/1ps

module reservation_station
	import ooo_pkg::*;
#(
	parameter  int ROB_DEPTH = 8,
	parameter  int RS_DEPTH  = 4,
	localparam int TAG_W     = $clog2(ROB_DEPTH),
	localparam int IDX_W     = $clog2(RS_DEPTH)
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             dispatch,
	input  alu_op_t          dispatch_op,
	input  logic [TAG_W-1:0] dispatch_tag,
	input  logic             op_a_ready,
	input  logic             op_b_ready,
	input  data_t            op_a_value,
	input  data_t            op_b_value,
	input  logic [TAG_W-1:0] op_a_tag,
	input  logic [TAG_W-1:0] op_b_tag,
	input  logic             cdb_valid,
	input  logic [TAG_W-1:0] cdb_tag,
	input  data_t            cdb_data,
	output logic             full,
	output logic             issue_valid,
	output alu_op_t          issue_op,
	output data_t            issue_a,
	output data_t            issue_b,
	output logic [TAG_W-1:0] issue_tag
);

	////////////////////////////////////////////////////////////
	// entry storage
	////////////////////////////////////////////////////////////

	logic [RS_DEPTH-1:0] busy;
	alu_op_t             op     [RS_DEPTH];
	logic [RS_DEPTH-1:0] a_rdy;
	logic [RS_DEPTH-1:0] b_rdy;
	data_t               a_val  [RS_DEPTH];
	data_t               b_val  [RS_DEPTH];
	logic [TAG_W-1:0]    a_tag  [RS_DEPTH];
	logic [TAG_W-1:0]    b_tag  [RS_DEPTH];
	// ROB entry the result goes to
	logic [TAG_W-1:0]    dst_tag [RS_DEPTH];

	logic [IDX_W-1:0] free_idx;
	logic [IDX_W-1:0] issue_idx;

	////////////////////////////////////////////////////////////
	// select logic
	////////////////////////////////////////////////////////////

	// scan high to low so the lowest index is the one left standing
	always_comb begin
		free_idx    = '0;
		issue_idx   = '0;
		issue_valid = 1'b0;
		for (int i = RS_DEPTH - 1; i >= 0; i--) begin
			if (!busy[i]) begin
				free_idx = IDX_W'(i);
			end
			if (busy[i] && a_rdy[i] && b_rdy[i]) begin
				issue_valid = 1'b1;
				issue_idx   = IDX_W'(i);
			end
		end
	end

	// issued entry frees only at the edge, so no same-cycle reuse
	assign full = &busy;

	// issue port reads straight from the chosen entry
	assign issue_op  = op[issue_idx];
	assign issue_a   = a_val[issue_idx];
	assign issue_b   = b_val[issue_idx];
	assign issue_tag = dst_tag[issue_idx];

	////////////////////////////////////////////////////////////
	// occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= '0;
		end else begin
			if (issue_valid) begin
				busy[issue_idx] <= 1'b0;
			end
			if (dispatch) begin
				busy[free_idx] <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// operand capture and wakeup
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		// snoop the CDB for every waiting operand
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (cdb_valid && !a_rdy[i] && a_tag[i] == cdb_tag) begin
				a_rdy[i] <= 1'b1;
				a_val[i] <= cdb_data;
			end
			if (cdb_valid && !b_rdy[i] && b_tag[i] == cdb_tag) begin
				b_rdy[i] <= 1'b1;
				b_val[i] <= cdb_data;
			end
		end
		// new entry, CDB forward already folded in by the core
		if (dispatch) begin
			op[free_idx]      <= dispatch_op;
			dst_tag[free_idx] <= dispatch_tag;
			a_rdy[free_idx]   <= op_a_ready;
			b_rdy[free_idx]   <= op_b_ready;
			a_val[free_idx]   <= op_a_value;
			b_val[free_idx]   <= op_b_value;
			a_tag[free_idx]   <= op_a_tag;
			b_tag[free_idx]   <= op_b_tag;
		end
	end

endmodule

/* design/rob/reorder_buffer.sv */
/*
 * circular ROB, ROB_DEPTH must be a power of two, tag is the entry index
 * commit of a done head is combinational, one retire per cycle at most
 */

`timescale 1ns/1ps

module reorder_buffer
	import ooo_pkg::*;
#(
	parameter  int ROB_DEPTH = 8,
	localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             dispatch,
	input  reg_idx_t         dispatch_rd,
	output logic [TAG_W-1:0] alloc_tag,
	output logic             full,
	input  logic [TAG_W-1:0] look_a_tag,
	input  logic [TAG_W-1:0] look_b_tag,
	output logic             look_a_done,
	output logic             look_b_done,
	output data_t            look_a_value,
	output data_t            look_b_value,
	input  logic             cdb_valid,
	input  logic [TAG_W-1:0] cdb_tag,
	input  data_t            cdb_data,
	output logic             commit_valid,
	output reg_idx_t         commit_rd,
	output logic [TAG_W-1:0] commit_tag,
	output data_t            commit_data
);

	////////////////////////////////////////////////////////////
	// pointers and entries
	////////////////////////////////////////////////////////////

	// pointers wrap on their own width
	logic [TAG_W-1:0] head;
	logic [TAG_W-1:0] tail;
	logic [TAG_W:0]   count;

	reg_idx_t             rd_q  [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] done;
	data_t                value [ROB_DEPTH];

	assign alloc_tag = tail;
	assign full      = (count == (TAG_W+1)'(ROB_DEPTH));

	// operand lookups, only meaningful for a tag the map says is live
	assign look_a_done  = done[look_a_tag];
	assign look_b_done  = done[look_b_tag];
	assign look_a_value = value[look_a_tag];
	assign look_b_value = value[look_b_tag];

	// head retires as soon as its result is in
	assign commit_valid = (count != '0) && done[head];
	assign commit_rd    = rd_q[head];
	assign commit_tag   = head;
	assign commit_data  = value[head];

	////////////////////////////////////////////////////////////
	// control state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			done  <= '0;
		end else begin
			if (dispatch) begin
				tail       <= tail + 1'b1;
				done[tail] <= 1'b0;
			end
			if (commit_valid) begin
				head <= head + 1'b1;
			end
			// the CDB tag is always an in-flight entry, never the tail
			if (cdb_valid) begin
				done[cdb_tag] <= 1'b1;
			end
			// dispatch plus commit leaves count as is
			case ({dispatch, commit_valid})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// payload
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (dispatch) begin
			rd_q[tail] <= dispatch_rd;
		end
		if (cdb_valid) begin
			value[cdb_tag] <= cdb_data;
		end
	end

endmodule

/* design/alu_unit.sv */
/*
 * single-cycle ALU, result registered and presented as the CDB next cycle
 * always accepts an issue, no back-pressure
 */

`timescale 1ns/1ps

module alu_unit
	import ooo_pkg::*;
#(
	parameter  int ROB_DEPTH = 8,
	localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             issue_valid,
	input  alu_op_t          issue_op,
	input  data_t            issue_a,
	input  data_t            issue_b,
	input  logic [TAG_W-1:0] issue_tag,
	output logic             cdb_valid,
	output logic [TAG_W-1:0] cdb_tag,
	output data_t            cdb_data
);

	data_t result;

	always_comb begin
		case (issue_op)
			ALU_ADD: result = issue_a + issue_b;
			ALU_SUB: result = issue_a - issue_b;
			ALU_AND: result = issue_a & issue_b;
			ALU_OR:  result = issue_a | issue_b;
			ALU_XOR: result = issue_a ^ issue_b;
			// shift amount from the low five bits only
			ALU_SLL: result = issue_a << issue_b[4:0];
			ALU_SLT: result = ($signed(issue_a) < $signed(issue_b)) ? 32'd1 : 32'd0;
			default: result = '0;
		endcase
	end

	// CDB valid
	always_ff @(posedge clock) begin
		if (reset) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= issue_valid;
		end
	end

	// CDB tag and data
	always_ff @(posedge clock) begin
		cdb_tag  <= issue_tag;
		cdb_data <= result;
	end

endmodule

/* design/ooo_core.sv */
/*
 * Tomasulo core top, one ALU on the CDB, in-order commit, no branches or memory
 * dispatch accepted when dispatch_valid is high and dispatch_stall is low
 */

`timescale 1ns/1ps

module ooo_core
	import ooo_pkg::*;
#(
	parameter int ROB_DEPTH = 8,
	parameter int RS_DEPTH  = 4
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     dispatch_valid,
	input  alu_op_t  dispatch_op,
	input  reg_idx_t dispatch_rd,
	input  reg_idx_t dispatch_rs1,
	input  reg_idx_t dispatch_rs2,
	input  logic     dispatch_use_imm,
	input  data_t    dispatch_imm,
	output logic     dispatch_stall,
	output logic     commit_valid,
	output reg_idx_t commit_rd,
	output data_t    commit_data
);

	localparam int TAG_W = $clog2(ROB_DEPTH);

	logic             dispatch;
	logic             rob_full;
	logic             rs_full;
	logic [TAG_W-1:0] alloc_tag;
	logic             src_a_busy, src_b_busy;
	logic [TAG_W-1:0] src_a_tag, src_b_tag;
	data_t            rf_a_data, rf_b_data;
	logic             look_a_done, look_b_done;
	data_t            look_a_value, look_b_value;
	logic             op_a_ready, op_b_ready, rs2_ready;
	data_t            op_a_value, op_b_value, rs2_value;
	logic             issue_valid;
	alu_op_t          issue_op;
	data_t            issue_a, issue_b;
	logic [TAG_W-1:0] issue_tag;
	logic             cdb_valid;
	logic [TAG_W-1:0] cdb_tag;
	data_t            cdb_data;
	logic [TAG_W-1:0] commit_tag;

	////////////////////////////////////////////////////////////
	// dispatch control
	////////////////////////////////////////////////////////////

	assign dispatch_stall = rob_full | rs_full;
	assign dispatch       = dispatch_valid & ~dispatch_stall;

	// operand source in priority order, returns {ready, value}
	function automatic logic [32:0] pick_source(
		input reg_idx_t         idx,
		input logic             busy,
		input logic [TAG_W-1:0] tag,
		input data_t            rf_val,
		input logic             rob_done,
		input data_t            rob_val
	);
		if (idx == '0) begin
			return {1'b1, 32'd0};
		end
		if (!busy) begin
			return {1'b1, rf_val};
		end
		if (rob_done) begin
			return {1'b1, rob_val};
		end
		// result landing on the CDB this very cycle
		if (cdb_valid && cdb_tag == tag) begin
			return {1'b1, cdb_data};
		end
		return {1'b0, 32'd0};
	endfunction

	assign {op_a_ready, op_a_value} = pick_source(dispatch_rs1, src_a_busy, src_a_tag,
		rf_a_data, look_a_done, look_a_value);
	assign {rs2_ready, rs2_value} = pick_source(dispatch_rs2, src_b_busy, src_b_tag,
		rf_b_data, look_b_done, look_b_value);

	// immediate replaces rs2
	assign op_b_ready = dispatch_use_imm | rs2_ready;
	assign op_b_value = dispatch_use_imm ? dispatch_imm : rs2_value;

	////////////////////////////////////////////////////////////
	// blocks
	////////////////////////////////////////////////////////////

	regfile u_regfile (
		.clock     (clock),
		.reset     (reset),
		.rd_a_idx  (dispatch_rs1),
		.rd_b_idx  (dispatch_rs2),
		.rd_a_data (rf_a_data),
		.rd_b_data (rf_b_data),
		.wr_en     (commit_valid && commit_rd != '0),
		.wr_idx    (commit_rd),
		.wr_data   (commit_data)
	);

	map_table #(.ROB_DEPTH(ROB_DEPTH)) u_map_table (
		.clock       (clock),
		.reset       (reset),
		.dispatch    (dispatch),
		.dispatch_rd (dispatch_rd),
		.alloc_tag   (alloc_tag),
		.src_a_idx   (dispatch_rs1),
		.src_b_idx   (dispatch_rs2),
		.src_a_busy  (src_a_busy),
		.src_b_busy  (src_b_busy),
		.src_a_tag   (src_a_tag),
		.src_b_tag   (src_b_tag),
		.commit      (commit_valid),
		.commit_rd   (commit_rd),
		.commit_tag  (commit_tag)
	);

	reservation_station #(.ROB_DEPTH(ROB_DEPTH), .RS_DEPTH(RS_DEPTH)) u_rs (
		.clock        (clock),
		.reset        (reset),
		.dispatch     (dispatch),
		.dispatch_op  (dispatch_op),
		.dispatch_tag (alloc_tag),
		.op_a_ready   (op_a_ready),
		.op_b_ready   (op_b_ready),
		.op_a_value   (op_a_value),
		.op_b_value   (op_b_value),
		.op_a_tag     (src_a_tag),
		.op_b_tag     (src_b_tag),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.cdb_data     (cdb_data),
		.full         (rs_full),
		.issue_valid  (issue_valid),
		.issue_op     (issue_op),
		.issue_a      (issue_a),
		.issue_b      (issue_b),
		.issue_tag    (issue_tag)
	);

	reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
		.clock        (clock),
		.reset        (reset),
		.dispatch     (dispatch),
		.dispatch_rd  (dispatch_rd),
		.alloc_tag    (alloc_tag),
		.full         (rob_full),
		.look_a_tag   (src_a_tag),
		.look_b_tag   (src_b_tag),
		.look_a_done  (look_a_done),
		.look_b_done  (look_b_done),
		.look_a_value (look_a_value),
		.look_b_value (look_b_value),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.cdb_data     (cdb_data),
		.commit_valid (commit_valid),
		.commit_rd    (commit_rd),
		.commit_tag   (commit_tag),
		.commit_data  (commit_data)
	);

	// sole producer on the CDB
	alu_unit #(.ROB_DEPTH(ROB_DEPTH)) u_alu (
		.clock       (clock),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_a     (issue_a),
		.issue_b     (issue_b),
		.issue_tag   (issue_tag),
		.cdb_valid   (cdb_valid),
		.cdb_tag     (cdb_tag),
		.cdb_data    (cdb_data)
	);

endmodule

/* dv/ooo_core_tb.sv */
/*
 * testbench for ooo_core, ROB_DEPTH 8 and RS_DEPTH 4, instruction table checked in program order
 * commit is sampled on the falling edge, dispatch changes on the rising edge
 */

`timescale 1ns/1ps

module ooo_core_tb
	import ooo_pkg::*;
;

	localparam int MAX_REC     = 128;
	localparam int STALL_LIMIT = 200;
	localparam int DRAIN_LIMIT = 1000;

	logic     clock;
	logic     reset;
	logic     dispatch_valid;
	alu_op_t  dispatch_op;
	reg_idx_t dispatch_rd;
	reg_idx_t dispatch_rs1;
	reg_idx_t dispatch_rs2;
	logic     dispatch_use_imm;
	data_t    dispatch_imm;
	logic     dispatch_stall;
	logic     commit_valid;
	reg_idx_t commit_rd;
	data_t    commit_data;

	////////////////////////////////////////////////////////////
	// instruction table and expected commits
	////////////////////////////////////////////////////////////

	alu_op_t  rec_op      [MAX_REC];
	reg_idx_t rec_rd      [MAX_REC];
	reg_idx_t rec_rs1     [MAX_REC];
	reg_idx_t rec_rs2     [MAX_REC];
	logic     rec_use_imm [MAX_REC];
	data_t    rec_imm     [MAX_REC];
	reg_idx_t exp_rd      [MAX_REC];
	data_t    exp_data    [MAX_REC];
	int       n_rec;
	int       n_commit;
	int       n_errors;
	logic     stall_seen;

	ooo_core #(.ROB_DEPTH(8), .RS_DEPTH(4)) u_ooo_core (
		.clock            (clock),
		.reset            (reset),
		.dispatch_valid   (dispatch_valid),
		.dispatch_op      (dispatch_op),
		.dispatch_rd      (dispatch_rd),
		.dispatch_rs1     (dispatch_rs1),
		.dispatch_rs2     (dispatch_rs2),
		.dispatch_use_imm (dispatch_use_imm),
		.dispatch_imm     (dispatch_imm),
		.dispatch_stall   (dispatch_stall),
		.commit_valid     (commit_valid),
		.commit_rd        (commit_rd),
		.commit_data      (commit_data)
	);

	// 8 ns period
	always #4 clock = ~clock;

	// reference ALU behavior, sll by b[4:0], slt signed
	function automatic data_t alu_result(input alu_op_t op, input data_t a, input data_t b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLL: return a << b[4:0];
			ALU_SLT: begin
				// signs differ, so a is less exactly when a is negative
				if (a[31] != b[31]) begin
					return {31'd0, a[31]};
				end
				return {31'd0, a < b};
			end
			default: return 32'd0;
		endcase
	endfunction

	task automatic add_rec(input alu_op_t op, input reg_idx_t rd, input reg_idx_t rs1,
		input reg_idx_t rs2, input logic use_imm, input data_t imm);
		rec_op[n_rec]      = op;
		rec_rd[n_rec]      = rd;
		rec_rs1[n_rec]     = rs1;
		rec_rs2[n_rec]     = rs2;
		rec_use_imm[n_rec] = use_imm;
		rec_imm[n_rec]     = imm;
		n_rec++;
	endtask

	// in-order golden run over the whole table
	task automatic run_golden_model();
		data_t gold [32];
		data_t b;
		for (int r = 0; r < 32; r++) begin
			gold[r] = '0;
		end
		for (int i = 0; i < n_rec; i++) begin
			b           = rec_use_imm[i] ? rec_imm[i] : gold[rec_rs2[i]];
			exp_rd[i]   = rec_rd[i];
			exp_data[i] = alu_result(rec_op[i], gold[rec_rs1[i]], b);
			// x0 stays zero even though its commit carries the result
			if (rec_rd[i] != '0) begin
				gold[rec_rd[i]] = exp_data[i];
			end
		end
	endtask

	task automatic abort_run(input string why);
		$display("timeout, %s", why);
		$display("errors %0d, commits %0d of %0d", n_errors, n_commit, n_rec);
		$display("test failed");
		$finish;
	endtask

	task automatic check_reset_state();
		if (commit_valid !== 1'b0) begin
			$display("error commit_valid expected %h actual %h", 1'b0, commit_valid);
			n_errors++;
		end
		if (dispatch_stall !== 1'b0) begin
			$display("error dispatch_stall expected %h actual %h", 1'b0, dispatch_stall);
			n_errors++;
		end
	endtask

	// called right after a rising edge, returns on the edge that accepts the record
	task automatic dispatch_record(input int i);
		int waited;
		dispatch_valid   <= 1'b1;
		dispatch_op      <= rec_op[i];
		dispatch_rd      <= rec_rd[i];
		dispatch_rs1     <= rec_rs1[i];
		dispatch_rs2     <= rec_rs2[i];
		dispatch_use_imm <= rec_use_imm[i];
		dispatch_imm     <= rec_imm[i];
		waited = 0;
		@(negedge clock);
		// stall only moves on a rising edge, so this is its value at the next one
		while (dispatch_stall) begin
			stall_seen = 1'b1;
			if (waited >= STALL_LIMIT) begin
				abort_run("dispatch_stall never dropped");
			end
			waited++;
			@(negedge clock);
		end
		@(posedge clock);
	endtask

	////////////////////////////////////////////////////////////
	// commit monitor
	////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		if (!reset && commit_valid) begin
			if (n_commit >= n_rec) begin
				$display("unexpected commit after the last record, rd %h data %h",
					commit_rd, commit_data);
				n_errors++;
			end else begin
				if (commit_rd !== exp_rd[n_commit]) begin
					$display("error commit_rd record %0d expected %h actual %h",
						n_commit, exp_rd[n_commit], commit_rd);
					n_errors++;
				end
				if (commit_data !== exp_data[n_commit]) begin
					$display("error commit_data record %0d expected %h actual %h",
						n_commit, exp_data[n_commit], commit_data);
					n_errors++;
				end
			end
			n_commit++;
		end
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int waited;
		clock            = 1'b0;
		reset            = 1'b1;
		dispatch_valid   = 1'b0;
		dispatch_op      = ALU_ADD;
		dispatch_rd      = '0;
		dispatch_rs1     = '0;
		dispatch_rs2     = '0;
		dispatch_use_imm = 1'b0;
		dispatch_imm     = '0;
		n_rec            = 0;
		n_commit         = 0;
		n_errors         = 0;
		stall_seen       = 1'b0;
		void'($urandom(32'hc74aff48));

		// independent ops, register then immediate forms
		add_rec(ALU_ADD, 1, 0, 0, 1, 32'h1234_5678);
		add_rec(ALU_ADD, 2, 0, 0, 1, 32'hffff_fff3);
		add_rec(ALU_ADD, 3, 0, 0, 1, 32'h0000_0005);
		add_rec(ALU_ADD, 4, 1, 2, 0, 0);
		add_rec(ALU_SUB, 5, 1, 2, 0, 0);
		add_rec(ALU_AND, 6, 1, 2, 0, 0);
		add_rec(ALU_OR, 7, 1, 3, 0, 0);
		add_rec(ALU_XOR, 8, 1, 2, 0, 0);
		add_rec(ALU_SLL, 9, 1, 3, 0, 0);
		add_rec(ALU_SLT, 10, 2, 1, 0, 0);
		add_rec(ALU_SLT, 11, 1, 2, 0, 0);
		add_rec(ALU_SUB, 12, 1, 0, 1, 32'h0000_0001);
		add_rec(ALU_AND, 13, 1, 0, 1, 32'hff00_ff00);
		add_rec(ALU_OR, 14, 2, 0, 1, 32'h0f0f_0000);
		add_rec(ALU_XOR, 15, 1, 0, 1, 32'hffff_ffff);
		// shift of 0x24 uses only 4
		add_rec(ALU_SLL, 16, 2, 0, 1, 32'h0000_0024);
		add_rec(ALU_SLT, 17, 2, 0, 1, 32'h0000_0000);
		// RAW, consumers at distance 1, 2 and 3 from x20
		add_rec(ALU_ADD, 20, 3, 0, 1, 32'h0000_0100);
		add_rec(ALU_ADD, 21, 20, 3, 0, 0);
		add_rec(ALU_XOR, 22, 20, 1, 0, 0);
		add_rec(ALU_SUB, 23, 2, 20, 0, 0);
		add_rec(ALU_OR, 24, 4, 5, 0, 0);
		add_rec(ALU_AND, 25, 6, 7, 0, 0);
		// producers long retired by now
		add_rec(ALU_ADD, 26, 20, 21, 0, 0);
		// WAW on x5, youngest value must win
		add_rec(ALU_ADD, 5, 0, 0, 1, 32'h0000_0001);
		add_rec(ALU_ADD, 5, 0, 0, 1, 32'h0000_0002);
		add_rec(ALU_ADD, 5, 5, 5, 0, 0);
		add_rec(ALU_ADD, 27, 5, 0, 1, 32'h0000_0000);
		add_rec(ALU_ADD, 0, 1, 2, 0, 0);
		add_rec(ALU_OR, 0, 0, 0, 1, 32'hdead_beef);
		add_rec(ALU_ADD, 28, 0, 1, 0, 0);
		add_rec(ALU_SUB, 29, 0, 0, 0, 0);
		// fillers then a serial chain on x30 to fill the RS and ROB
		add_rec(ALU_XOR, 18, 1, 2, 0, 0);
		add_rec(ALU_ADD, 19, 3, 4, 0, 0);
		add_rec(ALU_SUB, 24, 6, 1, 0, 0);
		add_rec(ALU_OR, 25, 7, 8, 0, 0);
		add_rec(ALU_ADD, 30, 3, 0, 1, 32'h0000_0001);
		for (int k = 0; k < 10; k++) begin
			add_rec((k % 2) ? ALU_XOR : ALU_ADD, 30, 30, 0, 1, data_t'(k * 3 + 1));
		end
		add_rec(ALU_ADD, 31, 30, 30, 0, 0);
		// random stream over x0 to x7
		for (int k = 0; k < 60; k++) begin
			alu_op_t  r_op;
			reg_idx_t r_rd;
			reg_idx_t r_rs1;
			reg_idx_t r_rs2;
			logic     r_imm;
			r_op  = alu_op_t'($urandom % 7);
			r_rd  = reg_idx_t'($urandom % 8);
			r_rs1 = reg_idx_t'($urandom % 8);
			r_rs2 = reg_idx_t'($urandom % 8);
			r_imm = 1'($urandom % 2);
			add_rec(r_op, r_rd, r_rs1, r_rs2, r_imm, $urandom);
		end
		run_golden_model();

		// two reset edges, then one cycle after release
		@(posedge clock);
		@(negedge clock);
		check_reset_state();
		@(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_reset_state();
		@(posedge clock);

		for (int i = 0; i < n_rec; i++) begin
			dispatch_record(i);
		end
		dispatch_valid <= 1'b0;

		// n_commit moves on the falling edge, read it on the rising one
		waited = 0;
		while (n_commit < n_rec) begin
			if (waited >= DRAIN_LIMIT) begin
				abort_run("not every record committed");
			end
			waited++;
			@(posedge clock);
		end
		// quiet period so a stray commit would show
		repeat (20) @(posedge clock);

		if (!stall_seen) begin
			$display("dispatch_stall never went high during the run");
			n_errors++;
		end
		$display("errors %0d, commits %0d of %0d", n_errors, n_commit, n_rec);
		if (n_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* all.f */
common/ooo_pkg.sv
design/regfile.sv
design/map_table.sv
design/rs/reservation_station.sv
design/rob/reorder_buffer.sv
design/alu_unit.sv
design/ooo_core.sv
dv/ooo_core_tb.sv
